// ==== verilog/net_pkg.sv ====
package net_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Ethernet
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [15:0] ETH_TYPE_IP  = 16'h0800;
    localparam logic [15:0] ETH_TYPE_ARP = 16'h0806;

    localparam int ETH_HDR_BYTES = 14;  // Dst MAC, src MAC, EtherType

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ARP
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [15:0] {
        ARP_REQUEST = 16'd1,
        ARP_REPLY   = 16'd2
    } arp_op_t;

    localparam logic [15:0] ARP_HTYPE_ETH = 16'h0001;   // Hardware type Ethernet
    localparam logic [7:0]  ARP_HLEN      = 8'd6;       // MAC address size
    localparam logic [7:0]  ARP_PLEN      = 8'd4;       // IPv4 address size

    localparam int ARP_BODY_BYTES = 28;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // IPv4
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [7:0]  IP_VER_IHL   = 8'h45;      // Version 4, five words
    localparam logic [7:0]  IP_TOS       = 8'h00;
    localparam logic [15:0] IP_FLAGS_DF  = 16'h4000;   // Don't fragment, offset 0
    localparam logic [7:0]  IP_TTL       = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP = 8'd17;

    localparam int IP_HDR_BYTES = 20;

endpackage

// ==== verilog/tx_fsm_pkg.sv ====
package tx_fsm_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MAC framer states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One HDR state walks all 14 header bytes with a byte counter
    typedef enum logic [2:0] {
        MAC_IDLE,
        MAC_WAIT,   // Waiting for fs
        MAC_HDR,
        MAC_WORK,   // Engine bytes pass through
        MAC_DONE    // fd held until fs drops
    } mac_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Payload engine states, shared by the ARP and IPv4 engines
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_LEAD,   // Lines the first byte up with the MAC header end
        ENG_SEND,
        ENG_FIN     // Output zero, fd high until start drops
    } eng_state_t;

    // Start is sampled two header bytes early, so both engines
    // idle in LEAD for this many cycles before byte 0
    localparam int LEAD_CYCLES = 2;

endpackage

// ==== verilog/mac_tx.sv ====
`timescale 1ns/10ps

module mac_tx
    import net_pkg::*, tx_fsm_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic [47:0] src_mac_addr,
    input  logic [47:0] det_mac_addr,

    input  logic        fs,
    output logic        fd,

    input  logic [15:0] mac_mode,

    output logic        fs_ip,
    input  logic        fd_ip,
    output logic        fs_arp,
    input  logic        fd_arp,

    input  logic [7:0]  mac_mode_txd,
    output logic [7:0]  txd,
    output logic        tx_en
);

    localparam logic [3:0] HDR_LAST  = 4'(ETH_HDR_BYTES - 1);
    localparam logic [3:0] ENG_START = 4'd10;  // Engine start lands at e11

    mac_state_t state, next_state;

    logic [3:0] hdr_cnt;
    logic [3:0] hdr_idx;
    logic [ETH_HDR_BYTES-1:0][7:0] hdr;
    logic fd_up;
    logic fd_up_s0;

    // Byte 0 sits in the top slot
    assign hdr     = {det_mac_addr, src_mac_addr, mac_mode};
    assign hdr_idx = HDR_LAST - hdr_cnt;

    assign fd_up = fd_ip | fd_arp;
    assign fd    = (state == MAC_DONE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MAC_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MAC_IDLE: next_state = MAC_WAIT;
            MAC_WAIT: if (fs) next_state = MAC_HDR;
            MAC_HDR:  if (hdr_cnt == HDR_LAST) next_state = MAC_WORK;
            MAC_WORK: if (fd_up_s0) next_state = MAC_DONE;
            MAC_DONE: if (!fs) next_state = MAC_WAIT;
            default:  next_state = MAC_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdr_cnt <= '0;
        end else if (state == MAC_HDR && hdr_cnt != HDR_LAST) begin
            hdr_cnt <= hdr_cnt + 4'd1;
        end else begin
            hdr_cnt <= '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            txd   <= '0;
            tx_en <= 1'b0;
        end else begin
            case (state)
                MAC_HDR:  txd <= hdr[hdr_idx];
                MAC_WORK: txd <= mac_mode_txd;   // Engine drives 0 in FIN
                default:  txd <= '0;
            endcase
            // Stays up for the one zero byte seen while fd_up is registered
            tx_en <= (state == MAC_HDR) || (state == MAC_WORK && !fd_up_s0);
        end
    end

    // Only the engine matching the EtherType is started
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_ip  <= 1'b0;
            fs_arp <= 1'b0;
        end else if (state == MAC_HDR && hdr_cnt == ENG_START) begin
            fs_ip  <= (mac_mode == ETH_TYPE_IP);
            fs_arp <= (mac_mode == ETH_TYPE_ARP);
        end else if (state != MAC_HDR && state != MAC_WORK) begin
            fs_ip  <= 1'b0;
            fs_arp <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd_up_s0 <= 1'b0;
        end else begin
            fd_up_s0 <= fd_up;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_one_engine: assert property (@(posedge clk) disable iff (rst)
        !(fs_ip && fs_arp))
        else $error("Both payload engines started");

    a_no_tx_when_done: assert property (@(posedge clk) disable iff (rst)
        fd |-> !tx_en)
        else $error("tx_en high while fd is high");

endmodule

// ==== verilog/arp_tx.sv ====
`timescale 1ns/10ps

module arp_tx
    import net_pkg::*, tx_fsm_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        fs,
    output logic        fd,

    input  logic [47:0] src_mac,
    input  logic [31:0] src_ip,
    input  logic [47:0] target_mac,
    input  logic [31:0] dst_ip,
    input  arp_op_t     arp_op,

    output logic [7:0]  txd
);

    localparam logic [4:0] BODY_LAST = 5'(ARP_BODY_BYTES - 1);
    localparam logic [4:0] LEAD_LAST = 5'(LEAD_CYCLES - 1);

    eng_state_t state;

    logic [4:0] cnt;
    logic [4:0] idx;
    logic [ARP_BODY_BYTES-1:0][7:0] body;

    // Request or reply, target_mac goes out as given
    assign body = {ARP_HTYPE_ETH, ETH_TYPE_IP, ARP_HLEN, ARP_PLEN, arp_op,
                   src_mac, src_ip,
                   target_mac, dst_ip};

    assign idx = BODY_LAST - cnt;
    assign txd = (state == ENG_SEND) ? body[idx] : 8'h00;
    assign fd  = (state == ENG_FIN);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ENG_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    cnt <= '0;
                    if (fs) state <= ENG_LEAD;
                end
                ENG_LEAD: begin
                    if (cnt == LEAD_LAST) begin
                        state <= ENG_SEND;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                ENG_SEND: begin
                    if (cnt == BODY_LAST) state <= ENG_FIN;
                    else cnt <= cnt + 5'd1;
                end
                ENG_FIN: begin
                    if (!fs) state <= ENG_IDLE;   // Start level drops in MAC DONE
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Body ends after its last byte and the output goes quiet
    a_quiet_outside_send: assert property (@(posedge clk) disable iff (rst)
        (state == ENG_SEND && cnt == BODY_LAST) |=> (state != ENG_SEND && txd == 8'h00))
        else $error("ARP engine drives data outside SEND");

endmodule

// ==== verilog/ip_tx.sv ====
`timescale 1ns/10ps

module ip_tx
    import net_pkg::*, tx_fsm_pkg::*;
#(
    parameter logic [15:0] PAYLOAD_LEN = 16'd18
)(
    input  logic        clk,
    input  logic        rst,

    input  logic        fs,
    output logic        fd,

    input  logic [31:0] src_ip,
    input  logic [31:0] dst_ip,
    input  logic [15:0] ip_id,

    input  logic [7:0]  payload_data,
    output logic        payload_rd,

    output logic [7:0]  txd
);

    localparam logic [15:0] HDR_LEN   = 16'(IP_HDR_BYTES);
    localparam logic [15:0] TOTAL_LEN = HDR_LEN + PAYLOAD_LEN;
    localparam logic [15:0] LAST      = TOTAL_LEN - 16'd1;
    localparam logic [15:0] LEAD_LAST = 16'(LEAD_CYCLES - 1);

    eng_state_t state;

    logic [15:0] cnt;
    logic        in_hdr;
    logic [4:0]  hdr_idx;
    logic [IP_HDR_BYTES-1:0][7:0] hdr;

    logic [19:0] sum;
    logic [19:0] sum_q;
    logic [16:0] fold1;
    logic [15:0] fold2;
    logic [15:0] csum_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Header checksum, two cycles in LEAD
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign sum = 20'({IP_VER_IHL, IP_TOS}) + 20'(TOTAL_LEN) + 20'(ip_id)
               + 20'(IP_FLAGS_DF) + 20'({IP_TTL, IP_PROTO_UDP})
               + 20'(src_ip[31:16]) + 20'(src_ip[15:0])
               + 20'(dst_ip[31:16]) + 20'(dst_ip[15:0]);

    // Second fold cannot carry again
    assign fold1 = 17'(sum_q[15:0]) + 17'(sum_q[19:16]);
    assign fold2 = fold1[15:0] + 16'(fold1[16]);

    always_ff @(posedge clk) begin
        if (state == ENG_LEAD) begin
            sum_q  <= sum;
            csum_q <= ~fold2;    // Valid after the last LEAD edge
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign hdr = {IP_VER_IHL, IP_TOS, TOTAL_LEN,
                  ip_id, IP_FLAGS_DF,
                  IP_TTL, IP_PROTO_UDP, csum_q,
                  src_ip, dst_ip};

    assign in_hdr  = (cnt < HDR_LEN);
    assign hdr_idx = 5'(IP_HDR_BYTES - 1) - cnt[4:0];

    // Source answers within the cycle, MAC samples on the next edge
    assign payload_rd = (state == ENG_SEND) && !in_hdr;

    always_comb begin
        if (state != ENG_SEND) txd = 8'h00;
        else if (in_hdr) txd = hdr[hdr_idx];
        else txd = payload_data;
    end

    assign fd = (state == ENG_FIN);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ENG_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    cnt <= '0;
                    if (fs) state <= ENG_LEAD;
                end
                ENG_LEAD: begin
                    if (cnt == LEAD_LAST) begin
                        state <= ENG_SEND;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                ENG_SEND: begin
                    if (cnt == LAST) state <= ENG_FIN;
                    else cnt <= cnt + 16'd1;
                end
                ENG_FIN: if (!fs) state <= ENG_IDLE;
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Each strobe follows a SEND cycle that had reached the last header byte
    a_rd_after_hdr: assert property (@(posedge clk) disable iff (rst)
        payload_rd |-> $past(state == ENG_SEND && cnt >= HDR_LEN - 16'd1))
        else $error("payload_rd outside the payload phase");

endmodule

// ==== verilog/eth_tx_top.sv ====
`timescale 1ns/10ps

module eth_tx_top
    import net_pkg::*;
#(
    parameter logic [15:0] PAYLOAD_LEN = 16'd18
)(
    input  logic        clk,
    input  logic        rst,

    input  logic        fs,
    output logic        fd,
    input  logic [15:0] mac_mode,     // EtherType, selects the engine

    input  logic [47:0] src_mac,
    input  logic [47:0] dst_mac,
    input  logic [31:0] src_ip,
    input  logic [31:0] dst_ip,
    input  logic [47:0] target_mac,
    input  arp_op_t     arp_op,
    input  logic [15:0] ip_id,

    input  logic [7:0]  payload_data,
    output logic        payload_rd,

    output logic [7:0]  txd,
    output logic        tx_en
);

    logic       fs_ip, fd_ip;
    logic       fs_arp, fd_arp;
    logic [7:0] ip_txd, arp_txd;
    logic [7:0] mac_mode_txd;

    // Idle engines drive zero
    assign mac_mode_txd = ip_txd | arp_txd;

    mac_tx mac0 (
        .clk          (clk),
        .rst          (rst),
        .src_mac_addr (src_mac),
        .det_mac_addr (dst_mac),
        .fs           (fs),
        .fd           (fd),
        .mac_mode     (mac_mode),
        .fs_ip        (fs_ip),
        .fd_ip        (fd_ip),
        .fs_arp       (fs_arp),
        .fd_arp       (fd_arp),
        .mac_mode_txd (mac_mode_txd),
        .txd          (txd),
        .tx_en        (tx_en)
    );

    ip_tx #(.PAYLOAD_LEN(PAYLOAD_LEN)) ip0 (
        .clk          (clk),
        .rst          (rst),
        .fs           (fs_ip),
        .fd           (fd_ip),
        .src_ip       (src_ip),
        .dst_ip       (dst_ip),
        .ip_id        (ip_id),
        .payload_data (payload_data),
        .payload_rd   (payload_rd),
        .txd          (ip_txd)
    );

    arp_tx arp0 (
        .clk          (clk),
        .rst          (rst),
        .fs           (fs_arp),
        .fd           (fd_arp),
        .src_mac      (src_mac),
        .src_ip       (src_ip),
        .target_mac   (target_mac),
        .dst_ip       (dst_ip),
        .arp_op       (arp_op),
        .txd          (arp_txd)
    );

endmodule

// ==== test/eth_tx_tb.sv ====
`timescale 1ns/10ps

module eth_tx_tb
    import net_pkg::*;
();

    localparam logic [15:0] PAYLOAD_LEN = 16'd18;
    localparam int TIMEOUT = 200;   // Cycles allowed per wait

    logic        clk = 1'b0;
    logic        rst, fs, fd, tx_en, payload_rd;
    logic [15:0] mac_mode, ip_id;
    logic [47:0] src_mac, dst_mac, target_mac;
    logic [31:0] src_ip, dst_ip;
    arp_op_t     arp_op;
    logic [7:0]  payload_data, txd;

    logic [7:0]  pay_state;     // Payload source state
    int          rd_count;
    logic [7:0]  got_q[$];      // Bytes seen with tx_en high

    eth_tx_top #(.PAYLOAD_LEN(PAYLOAD_LEN)) dut0 (
        .clk          (clk),
        .rst          (rst),
        .fs           (fs),
        .fd           (fd),
        .mac_mode     (mac_mode),
        .src_mac      (src_mac),
        .dst_mac      (dst_mac),
        .src_ip       (src_ip),
        .dst_ip       (dst_ip),
        .target_mac   (target_mac),
        .arp_op       (arp_op),
        .ip_id        (ip_id),
        .payload_data (payload_data),
        .payload_rd   (payload_rd),
        .txd          (txd),
        .tx_en        (tx_en)
    );

    always #10 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [7:0] xorshift8(input logic [7:0] x);
        logic [7:0] s;
        s = x ^ (x << 7);
        s = s ^ (s >> 5);
        return s ^ (s << 3);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_val(input logic [47:0] got, input logic [47:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "Run stopped at first mismatch");
        end
    endtask

    // One clock; the source answers a strobe before the next rising edge
    task automatic step_cycle();
        @(negedge clk);
        if (payload_rd === 1'b1) begin
            pay_state = xorshift8(pay_state);
            payload_data = pay_state;
            rd_count++;
        end
    endtask

    task automatic wait_tx_en();
        int n;
        n = 0;
        while (tx_en !== 1'b1) begin
            if (n == TIMEOUT) abort_run("Timed out waiting for tx_en to rise");
            step_cycle();
            n++;
        end
    endtask

    task automatic wait_fd(input logic level);
        int n;
        n = 0;
        while (fd !== level) begin
            if (n == TIMEOUT) abort_run($sformatf("Timed out waiting for fd = %0b", level));
            step_cycle();
            n++;
        end
    endtask

    task automatic collect_frame();
        int n;
        n = 0;
        got_q.delete();
        while (tx_en === 1'b1) begin
            if (n == TIMEOUT) abort_run("tx_en stayed high longer than any frame");
            got_q.push_back(txd);
            step_cycle();
            n++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int          fh, code, n_frames, exp_len, exp_rd;
        string       line;
        logic [15:0] op_v, cnt_v;
        logic [7:0]  seed_v, byte_v, s;

        rst = 1'b1;
        fs = 1'b0;
        mac_mode = '0;
        ip_id = '0;
        src_mac = '0;
        dst_mac = '0;
        target_mac = '0;
        src_ip = '0;
        dst_ip = '0;
        arp_op = ARP_REQUEST;
        payload_data = '0;
        pay_state = '0;
        rd_count = 0;

        fh = $fopen("test/eth_tx_golden.txt", "r");
        if (fh == 0) abort_run("Cannot open test/eth_tx_golden.txt");
        void'($fgets(line, fh));    // Column notes
        void'($fgets(line, fh));
        code = $fscanf(fh, "%h", n_frames);
        if (code != 1) abort_run("Golden file has no frame count");

        repeat (2) @(negedge clk);
        rst = 1'b0;

        repeat (3) begin
            check_val(48'(txd), 48'h0, "txd after reset");
            check_val(48'({tx_en, fd, payload_rd}), 48'h0, "tx_en/fd/payload_rd after reset");
            step_cycle();
        end

        for (int f = 0; f < n_frames; f++) begin
            code = $fscanf(fh, "%h %h %h %h %h %h %h %h %h %h", mac_mode, dst_mac, src_mac,
                           src_ip, dst_ip, target_mac, op_v, ip_id, seed_v, cnt_v);
            if (code != 10) abort_run($sformatf("Golden record %0d is incomplete", f));
            arp_op = arp_op_t'(op_v);
            pay_state = seed_v;
            rd_count = 0;
            fs = 1'b1;

            wait_tx_en();
            collect_frame();
            wait_fd(1'b1);

            if (mac_mode == ETH_TYPE_ARP) begin
                exp_len = ETH_HDR_BYTES + ARP_BODY_BYTES + 1;
                exp_rd = 0;
            end else begin
                exp_len = ETH_HDR_BYTES + IP_HDR_BYTES + int'(PAYLOAD_LEN) + 1;
                exp_rd = int'(PAYLOAD_LEN);
            end
            check_val(48'(got_q.size()), 48'(exp_len), $sformatf("frame %0d length", f));
            check_val(48'(cnt_v), 48'(exp_len), $sformatf("golden count of frame %0d", f));
            check_val(48'(rd_count), 48'(exp_rd), "payload_rd pulses");

            for (int i = 0; i < int'(cnt_v); i++) begin
                code = $fscanf(fh, "%h", byte_v);
                if (code != 1) abort_run($sformatf("Golden frame %0d is short", f));
                check_val(48'(got_q[i]), 48'(byte_v), $sformatf("frame %0d byte %0d", f, i));
            end

            check_val(48'({got_q[12], got_q[13]}), 48'(mac_mode), "EtherType");
            check_val(48'(got_q[exp_len - 1]), 48'h0, "trailing byte");
            if (mac_mode == ETH_TYPE_ARP) begin
                check_val(48'({got_q[20], got_q[21]}), 48'(op_v), "ARP opcode");
            end else begin
                check_val(48'({got_q[16], got_q[17]}),
                          48'(IP_HDR_BYTES + int'(PAYLOAD_LEN)), "IPv4 total length");
                s = seed_v;
                for (int i = 0; i < int'(PAYLOAD_LEN); i++) begin
                    s = xorshift8(s);
                    check_val(48'(got_q[ETH_HDR_BYTES + IP_HDR_BYTES + i]), 48'(s),
                              $sformatf("payload byte %0d", i));
                end
            end

            // fd stays up while fs is held, drops once fs goes low
            repeat (3) begin
                step_cycle();
                check_val(48'(fd), 48'h1, "fd while fs held");
                check_val(48'(tx_en), 48'h0, "tx_en with fd high");
            end
            fs = 1'b0;
            wait_fd(1'b0);
        end

        $fclose(fh);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== test/eth_tx_golden.txt ====
# Per frame (hex): mode dst_mac src_mac src_ip dst_ip target_mac arp_op ip_id payload_seed count
# then count txd bytes seen while tx_en is high; the first value is the number of frames
03

0806 ffffffffffff 020000a1b2c3 c0a80102 c0a80164 000000000000 0001 0000 17 2b
ff ff ff ff ff ff 02 00 00 a1 b2 c3 08 06
00 01 08 00 06 04 00 01
02 00 00 a1 b2 c3 c0 a8 01 02
00 00 00 00 00 00 c0 a8 01 64
00

0806 021122334455 0a1b2c3d4e5f 0a000001 0a0000fe 021122334455 0002 0000 17 2b
02 11 22 33 44 55 0a 1b 2c 3d 4e 5f 08 06
00 01 08 00 06 04 00 02
0a 1b 2c 3d 4e 5f 0a 00 00 01
02 11 22 33 44 55 0a 00 00 fe
00

0800 021122334455 020000a1b2c3 c0a80102 c0a80164 000000000000 0001 1c46 17 35
02 11 22 33 44 55 02 00 00 a1 b2 c3 08 00
45 00 00 26 1c 46 40 00 40 11 9a ca
c0 a8 01 02 c0 a8 01 64
0b f7 d4 42 40 52 d0 66 4d
93 8b 53 7d 2a 73 54 e6 e9
00

// ==== eth_tx.f ====
verilog/net_pkg.sv
verilog/tx_fsm_pkg.sv
verilog/mac_tx.sv
verilog/arp_tx.sv
verilog/ip_tx.sv
verilog/eth_tx_top.sv
test/eth_tx_tb.sv

// ==== Makefile ====
# Verilator build and run for the Ethernet transmit testbench
TOP       ?= eth_tx_tb
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -j 0
BUILD_DIR ?= obj_dir
FILELIST  ?= eth_tx.f

PASS_MSG  := Simulation finished: PASS
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
